// ==== testbench/uart_trace.txt ====
# columns: op addr data mask expect err name (numbers in hex)
# op: write, read, poll (until match), line (txd level), break (data = bit times)
line  0 00 00000001 00000001 0 reset_txd
read  4 00 00000007 00000000 0 reset_status
write 0 a5 00000000 00000000 0 loop_write
poll  4 00 00000002 00000002 0 loop_ready
read  0 00 000000ff 000000a5 0 loop_data
read  4 00 00000002 00000000 0 loop_ready_clear
write 0 3c 00000000 00000000 0 b2b_write_a
write 0 c3 00000000 00000000 0 b2b_write_b
poll  4 00 00000002 00000002 0 b2b_ready_a
read  0 00 000000ff 0000003c 0 b2b_data_a
poll  4 00 00000002 00000002 0 b2b_ready_b
read  0 00 000000ff 000000c3 0 b2b_data_b
write 0 11 00000000 00000000 0 ovf_write_a
write 0 22 00000000 00000000 0 ovf_write_b
write 0 33 00000000 00000000 1 ovf_write_c
poll  4 00 00000002 00000002 0 ovf_ready_a
read  0 00 000000ff 00000011 0 ovf_data_a
poll  4 00 00000002 00000002 0 ovf_ready_b
read  0 00 000000ff 00000022 0 ovf_data_b
poll  4 00 00000001 00000000 0 ovf_tx_idle
read  4 00 00000007 00000000 0 ovf_no_third
break 0 0c 00000000 00000000 0 brk_inject
poll  4 00 00000006 00000006 0 brk_status
read  0 00 000000ff 00000000 0 brk_data
read  4 00 00000006 00000000 0 brk_clear
write 0 5a 00000000 00000000 0 brk_after_write
poll  4 00 00000002 00000002 0 brk_after_ready
read  0 00 000000ff 0000005a 0 brk_after_data
write 8 77 00000000 00000000 1 bad_write
read  c 00 00000000 00000000 1 bad_read
read  4 00 00000007 00000000 0 bad_no_change

// ==== filelist.f ====
design/uart_pkg.sv
design/uart_bit_timer.sv
design/uart_hold_buf.sv
design/uart_tx_fsm.sv
design/uart_rx_fsm.sv
design/uart_apb_regs.sv
design/uart_top.sv
testbench/uart_assert.sv
testbench/tb_uart.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the UART testbench with Verilator and run it from the project root.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module tb_uart \
   -f filelist.f \
   -o tb_uart_sim

./obj_dir/tb_uart_sim | tee "$LOG"

if grep -q "TESTS PASSED" "$LOG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

// ==== testbench/tb_uart.sv ====
module tb_uart;

   timeunit 1ns;
   timeprecision 100ps;

   import uart_pkg::*;

   localparam int          CLK_PERIOD = 100;
   localparam int unsigned SEED       = 32'hbc14_fa70;
   localparam int          POLL_TRIES = 200;                // Reads per status poll.
   localparam string       TRACE_FILE = "testbench/uart_trace.txt";

   localparam logic [63:0] OP_WRITE = 64'("write");
   localparam logic [63:0] OP_READ  = 64'("read");
   localparam logic [63:0] OP_POLL  = 64'("poll");
   localparam logic [63:0] OP_LINE  = 64'("line");
   localparam logic [63:0] OP_BREAK = 64'("break");

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        rxd;
   logic        txd;
   logic        break_low;
   int          checks;
   int          value_errors;
   int          other_errors;
   int          assert_errors;

   uart_top i_dut
   (
      .clk_i     (clk),
      .rst_i     (rst),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr),
      .rxd_i     (rxd),
      .txd_o     (txd)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Serial loopback, pulled low while a break is injected.
   initial
   begin
      rxd = 1'b1;
      forever
      begin
         @(negedge clk);
         rxd = break_low ? 1'b0 : txd;
      end
   end

   // ==========================================================
   // Bus and line helpers
   // ==========================================================

   task automatic apb_access(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(negedge clk);
      psel    = 1'b1;                                       // Setup phase.
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #(CLK_PERIOD / 4);
      rdata = prdata;                                       // Settled before the edge.
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic poll_status(input logic [3:0] addr, input logic [31:0] mask,
                              input logic [31:0] exp_val, input logic [8*32-1:0] name);
      logic [31:0] rdata;
      logic        err;
      int          tries;

      apb_access(1'b0, addr, 32'h0, rdata, err);
      tries = 1;
      while (((rdata & mask) != exp_val) && (tries < POLL_TRIES))
      begin
         apb_access(1'b0, addr, 32'h0, rdata, err);
         tries++;
      end
      checks++;
      if ((rdata & mask) != exp_val)
      begin
         other_errors++;
         $display("Status poll %0s timed out after %0d reads", name, tries);
      end
   endtask

   // Low for the given bit times, then two idle bit times so the receiver
   // is out of its break hold-off before the next frame.
   task automatic inject_break(input logic [31:0] bits);
      break_low = 1'b1;
      repeat (bits * BIT_CYCLES) @(negedge clk);
      break_low = 1'b0;
      repeat (2 * BIT_CYCLES) @(negedge clk);
   endtask

   task automatic idle_gap();
      int unsigned cycles;

      cycles = $urandom % 4;
      repeat (cycles) @(negedge clk);
   endtask

   // ==========================================================
   // Trace player
   // ==========================================================

   task automatic play_trace();
      int              fd;
      int              code;
      string           text;
      logic [63:0]     op;
      logic [31:0]     addr;
      logic [31:0]     data;
      logic [31:0]     mask;
      logic [31:0]     exp_val;
      logic [31:0]     exp_err;
      logic [8*32-1:0] name;
      logic [31:0]     rdata;
      logic            err;

      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("Cannot open the trace file %s", TRACE_FILE);
      end
      else
      begin
         while (!$feof(fd))
         begin
            if ($fgets(text, fd) == 0)
               break;
            code = $sscanf(text, "%s %h %h %h %h %h %s", op, addr, data, mask,
                           exp_val, exp_err, name);
            if (code != 7)
               continue;                                    // Comment or blank.
            if ((op == OP_WRITE) || (op == OP_READ))
            begin
               apb_access(op == OP_WRITE, addr[3:0], data, rdata, err);
               checks++;
               if (err !== exp_err[0])
               begin
                  value_errors++;
                  $display("ERROR %0s: expected pslverr %0d, actual %0d",
                           name, exp_err[0], err);
               end
               if ((op == OP_READ) && (mask != '0))
               begin
                  checks++;
                  if ((rdata & mask) !== exp_val)
                  begin
                     value_errors++;
                     $display("ERROR %0s: expected %h, actual %h",
                              name, exp_val, rdata & mask);
                  end
               end
            end
            else if (op == OP_POLL)
               poll_status(addr[3:0], mask, exp_val, name);
            else if (op == OP_LINE)
            begin
               @(negedge clk);
               checks++;
               if (txd !== exp_val[0])
               begin
                  value_errors++;
                  $display("ERROR %0s: expected %b, actual %b", name, exp_val[0], txd);
               end
            end
            else if (op == OP_BREAK)
               inject_break(data);
            else
            begin
               other_errors++;
               $display("Unknown operation in trace line: %0s", text);
            end
            idle_gap();
         end
         $fclose(fd);
      end
   endtask

   // ==========================================================
   // Main sequence
   // ==========================================================

   initial
   begin
      logic [31:0] rdata;
      logic        err;

      rst           = 1'b1;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      break_low     = 1'b0;
      checks        = 0;
      value_errors  = 0;
      other_errors  = 0;
      assert_errors = 0;
      void'($urandom(SEED));

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      play_trace();

      // Everything drained at the end.
      apb_access(1'b0, ADDR_STATUS, 32'h0, rdata, err);
      checks++;
      if (rdata[ST_TX_BUSY] || rdata[ST_RX_READY] || rdata[ST_BREAK])
      begin
         value_errors++;
         $display("ERROR end_status: expected 000, actual %b", rdata[2:0]);
      end
      if (checks < 2)
      begin
         other_errors++;
         $display("The trace ran no checks");
      end

      assert_errors = i_dut.i_assert.failures;

      $display("Summary: %0d checks, %0d value errors, %0d other errors, %0d assertion errors",
               checks, value_errors, other_errors, assert_errors);
      if ((value_errors == 0) && (other_errors == 0) && (assert_errors == 0))
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== testbench/uart_assert.sv ====
module uart_assert
(
   input logic clk_i,
   input logic rst_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_i,
   input logic pslverr_i,
   input logic tx_busy_i,
   input logic txd_i
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned failures = 0;                               // Failed assertions so far.

   // ==========================================================
   // APB
   // ==========================================================

   a_ready_high : assert property (@(posedge clk_i) disable iff (rst_i) pready_i)
   else
   begin
      failures++;
      $error("pready_o went low");
   end

   a_err_in_access : assert property (@(posedge clk_i) disable iff (rst_i)
                                      pslverr_i |-> (psel_i && penable_i))
   else
   begin
      failures++;
      $error("pslverr_o outside an access cycle");
   end

   // ==========================================================
   // Serial line
   // ==========================================================

   a_txd_reset : assert property (@(posedge clk_i) rst_i |-> txd_i)
   else
   begin
      failures++;
      $error("txd_o low during reset");
   end

   a_txd_idle : assert property (@(posedge clk_i) disable iff (rst_i)
                                 !tx_busy_i |-> txd_i)
   else
   begin
      failures++;
      $error("txd_o low while the transmitter is idle");
   end

endmodule

bind uart_top uart_assert i_assert
(
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_i  (pready_o),
   .pslverr_i (pslverr_o),
   .tx_busy_i (tx_busy),
   .txd_i     (txd_o)
);

// ==== design/uart_top.sv ====
module uart_top
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        psel_i,
   input  logic        penable_i,
   input  logic        pwrite_i,
   input  logic [3:0]  paddr_i,
   input  logic [31:0] pwdata_i,
   output logic [31:0] prdata_o,
   output logic        pready_o,
   output logic        pslverr_o,
   input  logic        rxd_i,
   output logic        txd_o
);

   import uart_pkg::*;

   // Transmit path.
   logic       tx_push;
   logic [7:0] tx_wdata;
   logic       tx_pop;
   logic       tx_full;
   logic [7:0] tx_data;
   logic       tx_busy;
   logic       tx_load;
   logic       tx_half;
   logic       tx_expire;

   // Receive path.
   logic      rx_push;
   rx_entry_t rx_entry_in;
   logic      rx_pop;
   logic      rx_full;
   rx_entry_t rx_entry_out;
   logic      rx_load;
   logic      rx_half;
   logic      rx_expire;

   // ==========================================================
   // Bus side
   // ==========================================================

   uart_apb_regs i_regs
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .tx_full_i  (tx_full),
      .tx_busy_i  (tx_busy),
      .rx_full_i  (rx_full),
      .rx_entry_i (rx_entry_out),
      .tx_push_o  (tx_push),
      .tx_data_o  (tx_wdata),
      .rx_pop_o   (rx_pop)
   );

   // ==========================================================
   // Transmit
   // ==========================================================

   uart_hold_buf #(.payload_t(logic [7:0])) i_tx_buf
   (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .push_i (tx_push),
      .pop_i  (tx_pop),
      .data_i (tx_wdata),
      .data_o (tx_data),
      .full_o (tx_full)
   );

   uart_tx_fsm i_tx_fsm
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .buf_full_i (tx_full),
      .buf_data_i (tx_data),
      .expire_i   (tx_expire),
      .buf_pop_o  (tx_pop),
      .load_o     (tx_load),
      .half_o     (tx_half),
      .busy_o     (tx_busy),
      .txd_o      (txd_o)
   );

   uart_bit_timer i_tx_timer
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .load_i   (tx_load),
      .half_i   (tx_half),
      .expire_o (tx_expire)
   );

   // ==========================================================
   // Receive
   // ==========================================================

   uart_rx_fsm i_rx_fsm
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .rxd_i    (rxd_i),
      .expire_i (rx_expire),
      .load_o   (rx_load),
      .half_o   (rx_half),
      .push_o   (rx_push),
      .entry_o  (rx_entry_in)
   );

   uart_bit_timer i_rx_timer
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .load_i   (rx_load),
      .half_i   (rx_half),
      .expire_o (rx_expire)
   );

   // A new frame overwrites an unread one.
   uart_hold_buf #(.payload_t(rx_entry_t)) i_rx_buf
   (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .push_i (rx_push),
      .pop_i  (rx_pop || rx_push),
      .data_i (rx_entry_in),
      .data_o (rx_entry_out),
      .full_o (rx_full)
   );

endmodule

// ==== design/uart_apb_regs.sv ====
module uart_apb_regs
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  logic [3:0]          paddr_i,
   input  logic [31:0]         pwdata_i,
   output logic [31:0]         prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   input  logic                tx_full_i,
   input  logic                tx_busy_i,
   input  logic                rx_full_i,
   input  uart_pkg::rx_entry_t rx_entry_i,
   output logic                tx_push_o,
   output logic [7:0]          tx_data_o,
   output logic                rx_pop_o
);

   import uart_pkg::*;

   logic access;
   logic sel_data;
   logic sel_status;
   logic wr_data;
   logic rd_data;

   // ==========================================================
   // Decode
   // ==========================================================

   assign access     = psel_i && penable_i;
   assign sel_data   = (paddr_i == ADDR_DATA);
   assign sel_status = (paddr_i == ADDR_STATUS);
   assign wr_data    = access && pwrite_i && sel_data;
   assign rd_data    = access && !pwrite_i && sel_data;

   // ==========================================================
   // Strobes and response
   // ==========================================================

   assign tx_push_o = wr_data && !tx_full_i;                // Full drops the byte.
   assign tx_data_o = pwdata_i[7:0];
   assign rx_pop_o  = rd_data && rx_full_i;                 // Empty read is harmless.

   assign pready_o  = 1'b1;                                 // No wait states.

   always_comb
   begin
      pslverr_o = 1'b0;
      if (access)
      begin
         if (!sel_data && !sel_status)
            pslverr_o = 1'b1;                               // Undefined address.
         else if (wr_data && tx_full_i)
            pslverr_o = 1'b1;                               // Transmit overflow.
      end
   end

   // ==========================================================
   // Read mux
   // ==========================================================

   always_comb
   begin
      prdata_o = '0;
      if (sel_data)
      begin
         prdata_o[7:0] = rx_entry_i.data;
      end
      else if (sel_status)
      begin
         prdata_o[ST_TX_BUSY]  = tx_full_i || tx_busy_i;
         prdata_o[ST_RX_READY] = rx_full_i;
         prdata_o[ST_BREAK]    = rx_full_i && rx_entry_i.brk;
      end
   end

endmodule

// ==== design/uart_rx_fsm.sv ====
module uart_rx_fsm
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                rxd_i,
   input  logic                expire_i,
   output logic                load_o,
   output logic                half_o,
   output logic                push_o,
   output uart_pkg::rx_entry_t entry_o
);

   import uart_pkg::*;

   typedef enum logic [2:0]
   {
      IDLE,
      START_CHK,
      DATA,
      STOP,
      BREAK_WAIT
   } state_t;

   state_t     state_q;
   logic [2:0] bit_idx_q;
   logic [7:0] shift_q;
   logic       rxd_meta_q;
   logic       rxd_q;

   // ==========================================================
   // Input synchronizer
   // ==========================================================

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rxd_meta_q <= 1'b1;
         rxd_q      <= 1'b1;
      end
      else
      begin
         rxd_meta_q <= rxd_i;
         rxd_q      <= rxd_meta_q;
      end
   end

   // ==========================================================
   // Timer control and entry output
   // ==========================================================

   // Only the start edge asks for a half period.
   assign half_o = (state_q == IDLE);

   always_comb
   begin
      case (state_q)
         IDLE:       load_o = !rxd_q;
         START_CHK:  load_o = expire_i && !rxd_q;
         DATA:       load_o = expire_i;
         STOP:       load_o = expire_i && !rxd_q;           // Break hold-off.
         BREAK_WAIT: load_o = expire_i && !rxd_q;
         default:    load_o = 1'b0;
      endcase
   end

   assign push_o       = (state_q == STOP) && expire_i;
   assign entry_o.brk  = !rxd_q;
   assign entry_o.data = rxd_q ? shift_q : 8'h00;

   // ==========================================================
   // Sequencing
   // ==========================================================

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q   <= IDLE;
         bit_idx_q <= '0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               if (!rxd_q)
                  state_q <= START_CHK;
            end
            START_CHK:
            begin
               if (expire_i)
               begin
                  state_q   <= rxd_q ? IDLE : DATA;         // Glitch if high again.
                  bit_idx_q <= '0;
               end
            end
            DATA:
            begin
               if (expire_i)
               begin
                  if (bit_idx_q == 3'd7)
                     state_q <= STOP;
                  else
                     bit_idx_q <= bit_idx_q + 1'b1;
               end
            end
            STOP:
            begin
               if (expire_i)
                  state_q <= rxd_q ? IDLE : BREAK_WAIT;
            end
            BREAK_WAIT:
            begin
               // One more bit time, repeated while the line stays low, so a
               // long break is not taken for a new start bit.
               if (expire_i && rxd_q)
                  state_q <= IDLE;
            end
            default:
               state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if ((state_q == DATA) && expire_i)
         shift_q <= {rxd_q, shift_q[7:1]};                  // LSB arrives first.
   end

endmodule

// ==== design/uart_tx_fsm.sv ====
module uart_tx_fsm
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       buf_full_i,
   input  logic [7:0] buf_data_i,
   input  logic       expire_i,
   output logic       buf_pop_o,
   output logic       load_o,
   output logic       half_o,
   output logic       busy_o,
   output logic       txd_o
);

   typedef enum logic [1:0]
   {
      IDLE,
      START,
      DATA,
      STOP
   } state_t;

   state_t     state_q;
   logic [2:0] bit_idx_q;
   logic [7:0] shift_q;
   logic       take;
   logic       line_d;
   logic       txd_q;

   // ==========================================================
   // Strobes to the buffer and the timer
   // ==========================================================

   // A byte is taken at idle or right at the end of a stop bit.
   assign take = buf_full_i && ((state_q == IDLE) || ((state_q == STOP) && expire_i));

   assign buf_pop_o = take;
   assign load_o    = take || (expire_i && ((state_q == START) || (state_q == DATA)));
   assign half_o    = 1'b0;                                 // Always whole bits.
   assign busy_o    = (state_q != IDLE);

   // ==========================================================
   // Sequencing
   // ==========================================================

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q   <= IDLE;
         bit_idx_q <= '0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               if (take)
                  state_q <= START;
            end
            START:
            begin
               if (expire_i)
               begin
                  state_q   <= DATA;
                  bit_idx_q <= '0;
               end
            end
            DATA:
            begin
               if (expire_i)
               begin
                  if (bit_idx_q == 3'd7)
                     state_q <= STOP;
                  else
                     bit_idx_q <= bit_idx_q + 1'b1;
               end
            end
            STOP:
            begin
               if (expire_i)
                  state_q <= take ? START : IDLE;           // Next byte goes straight out.
            end
            default:
               state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (take)
         shift_q <= buf_data_i;
      else if ((state_q == DATA) && expire_i)
         shift_q <= {1'b0, shift_q[7:1]};                   // LSB first.
   end

   // Line level for the current state, registered once on the way out.
   always_comb
   begin
      case (state_q)
         START:   line_d = 1'b0;
         DATA:    line_d = shift_q[0];
         default: line_d = 1'b1;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         txd_q <= 1'b1;                                     // Line idles high.
      else
         txd_q <= line_d;
   end

   assign txd_o = txd_q;

endmodule

// ==== design/uart_hold_buf.sv ====
module uart_hold_buf
#(
   parameter type payload_t = logic [7:0]
)
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     push_i,
   input  logic     pop_i,
   input  payload_t data_i,
   output payload_t data_o,
   output logic     full_o
);

   logic     valid_q;
   payload_t data_q;
   logic     accept;

   // A push lands when the slot is free or is being emptied this cycle.
   assign accept = push_i && (!valid_q || pop_i);

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         valid_q <= 1'b0;
      end
      else if (accept)
      begin
         valid_q <= 1'b1;
      end
      else if (pop_i)
      begin
         valid_q <= 1'b0;
      end
   end

   // Keeps the last item after a pop.
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         data_q <= data_i;
      end
   end

   assign data_o = data_q;
   assign full_o = valid_q;

endmodule

// ==== design/uart_bit_timer.sv ====
module uart_bit_timer
(
   input  logic clk_i,
   input  logic rst_i,
   input  logic load_i,
   input  logic half_i,
   output logic expire_o
);

   import uart_pkg::*;

   logic [TIMER_W-1:0] count_q;
   logic [TIMER_W-1:0] reload;

   assign reload = half_i ? TIMER_W'(HALF_CYCLES) : TIMER_W'(BIT_CYCLES);

   // Counts down to zero and then holds there until the next load.
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         count_q <= '0;
      end
      else if (load_i)
      begin
         count_q <= reload;
      end
      else if (count_q != '0)
      begin
         count_q <= count_q - 1'b1;                         // Still running.
      end
   end

   // High in the last cycle of the period, so the edge that takes the
   // count to zero is the one where the state machine acts.
   assign expire_o = (count_q == TIMER_W'(1));

endmodule

// ==== design/uart_pkg.sv ====
package uart_pkg;

   // ==========================================================
   // Serial bit timing
   // ==========================================================

   localparam int BIT_CYCLES  = 16;                         // Clocks per serial bit.
   localparam int HALF_CYCLES = BIT_CYCLES / 2;             // Start edge to mid-bit.
   localparam int TIMER_W     = $clog2(BIT_CYCLES + 1);     // Holds BIT_CYCLES itself.

   // ==========================================================
   // Register map
   // ==========================================================

   localparam logic [3:0] ADDR_DATA   = 4'h0;
   localparam logic [3:0] ADDR_STATUS = 4'h4;

   // STATUS register bits.
   localparam int ST_TX_BUSY  = 0;
   localparam int ST_RX_READY = 1;
   localparam int ST_BREAK    = 2;

   // ==========================================================
   // Receive entry
   // ==========================================================

   typedef struct packed
   {
      logic       brk;                                     // Stop bit was low.
      logic [7:0] data;                                    // Zero on a break.
   } rx_entry_t;

endpackage
